//--- rtl/rename_pkg.sv
package rename_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int DISP_SIZE  = 2;   // dispatch lanes
  localparam int NUM_SRC    = 2;   // sources per instruction
  localparam int ARCH_REGS  = 32;
  localparam int REGIDX_W   = 5;
  localparam int FLIST_SIZE = 16;  // ids per lane free list
  localparam int RNID_SIZE  = ARCH_REGS + DISP_SIZE * FLIST_SIZE;
  localparam int RNID_W     = 6;
  localparam int WB_PORTS   = 2;

  typedef logic [REGIDX_W-1:0] regidx_t;
  typedef logic [RNID_W-1:0]   rnid_t;

  // --------------------------------------------------
  // dispatch side
  // --------------------------------------------------
  typedef struct packed {
    logic    valid;
    regidx_t idx;
  } reg_ref_t;

  typedef struct packed {
    logic                    valid;
    reg_ref_t                rd;
    reg_ref_t [NUM_SRC-1:0]  rs;
  } disp_inst_t;

  typedef disp_inst_t [DISP_SIZE-1:0] disp_grp_t;

  // renamed side
  typedef struct packed {
    rnid_t rnid;
    logic  ready;   // producer already written back
  } rn_src_t;

  typedef struct packed {
    logic                   valid;
    reg_ref_t               rd;
    rnid_t                  rd_rnid;
    rnid_t                  old_rnid;   // previous mapping of rd, freed at commit
    rn_src_t [NUM_SRC-1:0]  rs;
  } rn_inst_t;

  typedef rn_inst_t [DISP_SIZE-1:0] rn_grp_t;

  typedef struct packed {
    logic  [DISP_SIZE-1:0]  valid;      // one bit per lane
    rnid_t [DISP_SIZE-1:0]  old_rnid;
  } commit_t;

  typedef struct packed {
    logic  valid;
    rnid_t rnid;
  } wb_t;

  // lane takes a fresh id: live instruction writing a register other than x0
  function automatic logic needs_rnid(disp_inst_t inst);
    return inst.valid & inst.rd.valid & (inst.rd.idx != '0);
  endfunction

endpackage

//--- rtl/rn_freelist.sv
module rn_freelist #(
  parameter int INIT_BASE = 32
) (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_push,
  input  rename_pkg::rnid_t i_push_id,
  input  logic              i_pop,
  output rename_pkg::rnid_t o_pop_id,
  output logic              o_is_empty
);
  import rename_pkg::*;

  rnid_t                           r_list [FLIST_SIZE];
  logic [$clog2(FLIST_SIZE)-1:0]   r_head;   // next id handed out
  logic [$clog2(FLIST_SIZE)-1:0]   r_tail;   // slot for the next returned id
  logic [$clog2(FLIST_SIZE+1)-1:0] r_count;

  assign o_pop_id   = r_list[r_head];
  assign o_is_empty = (r_count == '0);

  // id storage, starts full with a contiguous block per lane
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < FLIST_SIZE; i++) begin
        r_list[i] <= rnid_t'(INIT_BASE + i);
      end
    end else if (i_push) begin
      r_list[r_tail] <= i_push_id;
    end
  end

  // pointers wrap on their own, size is a power of two
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= FLIST_SIZE[$clog2(FLIST_SIZE+1)-1:0];
    end else begin
      if (i_pop) begin
        r_head <= r_head + 1'b1;
      end
      if (i_push) begin
        r_tail <= r_tail + 1'b1;
      end
      case ({i_push, i_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;   // both or neither
      endcase
    end
  end

endmodule

//--- rtl/rn_map.sv
module rn_map (
  input  logic                                                          i_clk,
  input  logic                                                          i_reset_n,
  input  rename_pkg::regidx_t [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0] i_src_idx,
  output rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0]   o_src_rnid,
  input  rename_pkg::regidx_t [rename_pkg::DISP_SIZE-1:0]                          i_rd_idx,
  output rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0]                            o_rd_old_rnid,
  input  logic [rename_pkg::DISP_SIZE-1:0]                                         i_update,
  input  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0]                            i_update_rnid
);
  import rename_pkg::*;

  rnid_t r_map [ARCH_REGS];

  // --------------------------------------------------
  // group reads
  // --------------------------------------------------
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      for (int s = 0; s < NUM_SRC; s++) begin
        o_src_rnid[d][s] = r_map[i_src_idx[d][s]];
      end
      o_rd_old_rnid[d] = r_map[i_rd_idx[d]];   // mapping before this group
    end
  end

  // --------------------------------------------------
  // group update
  // --------------------------------------------------
  // lanes are walked in order so a later lane overwrites an earlier one
  // writing the same index
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        r_map[i] <= rnid_t'(i);   // identity
      end
    end else begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (i_update[d] && (i_rd_idx[d] != '0)) begin   // x0 stays on id 0
          r_map[i_rd_idx[d]] <= i_update_rnid[d];
        end
      end
    end
  end

endmodule

//--- rtl/rn_group_bypass.sv
module rn_group_bypass (
  input  rename_pkg::disp_grp_t                                                  i_disp,
  input  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0]                          i_new_rnid,
  input  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0] i_map_src_rnid,
  input  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0]                          i_map_old_rnid,
  output rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0] o_src_rnid,
  output logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0]              o_src_fwd,
  output rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0]                          o_old_rnid
);
  import rename_pkg::*;

  // the map still holds the state from before this group, so any earlier
  // lane writing the same register has to override it
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_old_rnid[d] = i_map_old_rnid[d];
      for (int s = 0; s < NUM_SRC; s++) begin
        o_src_rnid[d][s] = i_map_src_rnid[d][s];
        o_src_fwd[d][s]  = 1'b0;
      end

      // ascending scan, nearest earlier writer ends up last
      for (int p = 0; p < d; p++) begin
        if (needs_rnid(i_disp[p])) begin
          if (i_disp[p].rd.idx == i_disp[d].rd.idx) begin
            o_old_rnid[d] = i_new_rnid[p];   // old id is the one just allocated
          end
          for (int s = 0; s < NUM_SRC; s++) begin
            if (i_disp[d].rs[s].valid && (i_disp[p].rd.idx == i_disp[d].rs[s].idx)) begin
              o_src_rnid[d][s] = i_new_rnid[p];
              o_src_fwd[d][s]  = 1'b1;
            end
          end
        end
      end
    end
  end

endmodule

//--- rtl/rn_inflight.sv
module rn_inflight (
  input  logic                                                                   i_clk,
  input  logic                                                                   i_reset_n,
  input  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0] i_lookup_rnid,
  output logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0]              o_lookup_ready,
  input  logic [rename_pkg::DISP_SIZE-1:0]                                       i_alloc,
  input  rename_pkg::rnid_t [rename_pkg::DISP_SIZE-1:0]                          i_alloc_rnid,
  input  rename_pkg::wb_t [rename_pkg::WB_PORTS-1:0]                             i_wb
);
  import rename_pkg::*;

  logic [RNID_SIZE-1:0] r_ready;   // one bit per physical id

  // lookup, with same-cycle writeback bypass
  always_comb begin
    logic v_hit;
    for (int d = 0; d < DISP_SIZE; d++) begin
      for (int s = 0; s < NUM_SRC; s++) begin
        v_hit = 1'b0;
        for (int w = 0; w < WB_PORTS; w++) begin
          if (i_wb[w].valid && (i_wb[w].rnid == i_lookup_rnid[d][s])) begin
            v_hit = 1'b1;
          end
        end
        o_lookup_ready[d][s] = r_ready[i_lookup_rnid[d][s]] | v_hit |
                               (i_lookup_rnid[d][s] == '0);   // x0 is always ready
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ready <= '1;
    end else begin
      for (int w = 0; w < WB_PORTS; w++) begin
        if (i_wb[w].valid) begin
          r_ready[i_wb[w].rnid] <= 1'b1;
        end
      end
      // a freshly allocated id has no pending writeback, clear wins
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (i_alloc[d] && (i_alloc_rnid[d] != '0)) begin
          r_ready[i_alloc_rnid[d]] <= 1'b0;
        end
      end
    end
  end

endmodule

//--- rtl/rename_top.sv
module rename_top (
  input  logic                                      i_clk,
  input  logic                                      i_reset_n,
  input  logic                                      i_disp_valid,
  input  rename_pkg::disp_grp_t                     i_disp,
  input  logic                                      i_resource_ok,
  input  rename_pkg::commit_t                       i_commit,
  input  rename_pkg::wb_t [rename_pkg::WB_PORTS-1:0] i_wb,
  output logic                                      o_disp_ready,
  output logic                                      o_rn_valid,
  output rename_pkg::rn_grp_t                       o_rn
);
  import rename_pkg::*;

  logic                                  w_fire;
  logic    [DISP_SIZE-1:0]               w_flist_empty;
  logic    [DISP_SIZE-1:0]               w_alloc;   // lane wants a new id
  logic    [DISP_SIZE-1:0]               w_pop;     // lane takes it this cycle
  rnid_t   [DISP_SIZE-1:0]               w_head_id;
  rnid_t   [DISP_SIZE-1:0]               w_new_rnid;
  regidx_t [DISP_SIZE-1:0]               w_rd_idx;
  rnid_t   [DISP_SIZE-1:0]               w_map_old_rnid;
  rnid_t   [DISP_SIZE-1:0]               w_old_rnid;
  regidx_t [DISP_SIZE-1:0][NUM_SRC-1:0]  w_src_idx;
  rnid_t   [DISP_SIZE-1:0][NUM_SRC-1:0]  w_map_src_rnid;
  rnid_t   [DISP_SIZE-1:0][NUM_SRC-1:0]  w_src_rnid;
  logic    [DISP_SIZE-1:0][NUM_SRC-1:0]  w_src_fwd;
  logic    [DISP_SIZE-1:0][NUM_SRC-1:0]  w_src_ready;
  commit_t                               r_commit;   // commit, one cycle late
  rn_grp_t                               w_rn;

  assign o_disp_ready = i_resource_ok & ~(|w_flist_empty);
  assign w_fire       = i_disp_valid & o_disp_ready;

  // --------------------------------------------------
  // per lane free lists
  // --------------------------------------------------
  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_lane
    assign w_alloc[d]    = needs_rnid(i_disp[d]);
    assign w_pop[d]      = w_fire & w_alloc[d];
    assign w_new_rnid[d] = w_alloc[d] ? w_head_id[d] : '0;   // x0 or no rd gets id 0
    assign w_rd_idx[d]   = i_disp[d].rd.idx;
    for (genvar s = 0; s < NUM_SRC; s++) begin : g_src
      assign w_src_idx[d][s] = i_disp[d].rs[s].idx;
    end

    rn_freelist #(
      .INIT_BASE (ARCH_REGS + d * FLIST_SIZE)
    ) u_freelist (
      .i_clk      (i_clk),
      .i_reset_n  (i_reset_n),
      .i_push     (r_commit.valid[d]),
      .i_push_id  (r_commit.old_rnid[d]),
      .i_pop      (w_pop[d]),
      .o_pop_id   (w_head_id[d]),
      .o_is_empty (w_flist_empty[d])
    );
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_commit <= '0;
    end else begin
      r_commit <= i_commit;
    end
  end

  rn_map u_map (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_src_idx     (w_src_idx),
    .o_src_rnid    (w_map_src_rnid),
    .i_rd_idx      (w_rd_idx),
    .o_rd_old_rnid (w_map_old_rnid),
    .i_update      (w_pop),
    .i_update_rnid (w_new_rnid)
  );

  rn_group_bypass u_bypass (
    .i_disp         (i_disp),
    .i_new_rnid     (w_new_rnid),
    .i_map_src_rnid (w_map_src_rnid),
    .i_map_old_rnid (w_map_old_rnid),
    .o_src_rnid     (w_src_rnid),
    .o_src_fwd      (w_src_fwd),
    .o_old_rnid     (w_old_rnid)
  );

  rn_inflight u_inflight (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_lookup_rnid  (w_src_rnid),
    .o_lookup_ready (w_src_ready),
    .i_alloc        (w_pop),
    .i_alloc_rnid   (w_new_rnid),
    .i_wb           (i_wb)
  );

  // --------------------------------------------------
  // output group
  // --------------------------------------------------
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_rn[d].valid    = i_disp[d].valid;
      w_rn[d].rd       = i_disp[d].rd;
      w_rn[d].rd_rnid  = w_new_rnid[d];
      w_rn[d].old_rnid = w_alloc[d] ? w_old_rnid[d] : '0;
      for (int s = 0; s < NUM_SRC; s++) begin
        if (i_disp[d].valid && i_disp[d].rs[s].valid) begin
          w_rn[d].rs[s].rnid  = w_src_rnid[d][s];
          // producer in the same group cannot be done yet
          w_rn[d].rs[s].ready = w_src_ready[d][s] & ~w_src_fwd[d][s];
        end else begin
          w_rn[d].rs[s].rnid  = '0;   // unused source
          w_rn[d].rs[s].ready = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_rn_valid <= 1'b0;
      o_rn       <= '0;
    end else begin
      o_rn_valid <= w_fire;   // single cycle strobe
      if (w_fire) begin
        o_rn <= w_rn;
      end
    end
  end

endmodule

//--- verification/tb_clkgen.sv
module tb_clkgen (
  output logic o_clk,
  output logic o_reset_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    o_clk     = 1'b0;
    o_reset_n = 1'b0;
    repeat (4) @(posedge o_clk);
    @(negedge o_clk);
    #2 o_reset_n = 1'b1;   // release away from both edges
  end

  always #4 o_clk = ~o_clk;   // 8 ns period

endmodule

//--- verification/rename_checker.sv
module rename_checker (
  input  logic                                      i_clk,
  input  logic                                      i_reset_n,
  input  logic                                      i_disp_valid,
  input  rename_pkg::disp_grp_t                     i_disp,
  input  logic                                      i_resource_ok,
  input  rename_pkg::commit_t                       i_commit,
  input  rename_pkg::wb_t [rename_pkg::WB_PORTS-1:0] i_wb,
  input  logic                                      i_disp_ready,
  input  logic                                      i_rn_valid,
  input  rename_pkg::rn_grp_t                       i_rn,
  output int                                        o_error_count,
  output int                                        o_check_count
);
  timeunit 1ns;
  timeprecision 1ps;
  import rename_pkg::*;

  rnid_t                m_map [ARCH_REGS];
  logic [RNID_SIZE-1:0] m_ready;
  rnid_t                m_flist [DISP_SIZE][$];
  commit_t              m_commit_d;
  rn_grp_t              m_exp;
  logic                 m_exp_valid;
  rnid_t                commit_pool [$];   // old ids free to commit, popped by the tb
  int                   err_edge, chk_edge, err_cmp, chk_cmp;

  assign o_error_count = err_edge + err_cmp;
  assign o_check_count = chk_edge + chk_cmp;

  initial begin
    err_edge = 0;
    chk_edge = 0;
    err_cmp  = 0;
    chk_cmp  = 0;
  end

  task automatic compare_field(input string name, input int exp, input int got);
    chk_cmp++;
    if (exp != got) begin
      err_cmp++;
      $display("FAILED %0t %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  // --------------------------------------------------
  // model update and prediction at each edge
  // --------------------------------------------------
  always @(posedge i_clk or negedge i_reset_n) begin
    logic                  exp_ready;
    logic [DISP_SIZE-1:0]  need;
    rnid_t [DISP_SIZE-1:0] new_id;
    rnid_t                 id;
    logic                  fwd;
    logic                  hit;
    if (!i_reset_n) begin
      for (int i = 0; i < ARCH_REGS; i++) m_map[i] = rnid_t'(i);
      m_ready = '1;
      for (int d = 0; d < DISP_SIZE; d++) begin
        m_flist[d].delete();
        for (int i = 0; i < FLIST_SIZE; i++) m_flist[d].push_back(rnid_t'(32 + d * 16 + i));
      end
      m_commit_d  = '0;
      m_exp_valid = 1'b0;
    end else begin
      exp_ready = i_resource_ok && (m_flist[0].size() != 0) && (m_flist[1].size() != 0);
      chk_edge++;
      if (i_disp_ready !== exp_ready) begin
        err_edge++;
        $display("FAILED %0t o_disp_ready expected %0h got %0h", $time, exp_ready, i_disp_ready);
      end
      m_exp_valid = i_disp_valid && exp_ready;
      for (int d = 0; d < DISP_SIZE; d++) begin
        need[d]   = i_disp[d].valid && i_disp[d].rd.valid && (i_disp[d].rd.idx != 0);
        new_id[d] = need[d] ? m_flist[d][0] : '0;
      end
      if (m_exp_valid) begin
        for (int d = 0; d < DISP_SIZE; d++) begin
          m_exp[d].valid    = i_disp[d].valid;
          m_exp[d].rd       = i_disp[d].rd;
          m_exp[d].rd_rnid  = new_id[d];
          m_exp[d].old_rnid = need[d] ? m_map[i_disp[d].rd.idx] : '0;
          for (int p = 0; p < d; p++) begin
            if (need[d] && need[p] && (i_disp[p].rd.idx == i_disp[d].rd.idx))
              m_exp[d].old_rnid = new_id[p];
          end
          for (int s = 0; s < NUM_SRC; s++) begin
            id  = '0;
            fwd = 1'b0;
            hit = 1'b1;
            if (i_disp[d].valid && i_disp[d].rs[s].valid) begin
              id = m_map[i_disp[d].rs[s].idx];
              for (int p = 0; p < d; p++) begin
                if (need[p] && (i_disp[p].rd.idx == i_disp[d].rs[s].idx)) begin
                  id  = new_id[p];
                  fwd = 1'b1;
                end
              end
              hit = m_ready[id] || (id == 0);
              for (int w = 0; w < WB_PORTS; w++) hit |= i_wb[w].valid && (i_wb[w].rnid == id);
            end
            m_exp[d].rs[s].rnid  = id;
            m_exp[d].rs[s].ready = hit && !fwd;
          end
        end
      end
      // state changes, allocation clears after writeback sets
      for (int w = 0; w < WB_PORTS; w++) if (i_wb[w].valid) m_ready[i_wb[w].rnid] = 1'b1;
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (m_exp_valid && need[d]) begin
          m_ready[new_id[d]]        = 1'b0;
          m_map[i_disp[d].rd.idx]   = new_id[d];
          void'(m_flist[d].pop_front());
        end
        if (m_commit_d.valid[d]) m_flist[d].push_back(m_commit_d.old_rnid[d]);
      end
      m_commit_d = i_commit;
    end
  end

  // output compare, half a cycle after the edge
  always @(negedge i_clk) begin
    if (i_reset_n) begin
      compare_field("o_rn_valid", m_exp_valid, i_rn_valid);
      if (m_exp_valid) begin
        for (int d = 0; d < DISP_SIZE; d++) begin
          compare_field($sformatf("o_rn[%0d].valid", d), m_exp[d].valid, i_rn[d].valid);
          compare_field($sformatf("o_rn[%0d].rd", d), m_exp[d].rd, i_rn[d].rd);
          compare_field($sformatf("o_rn[%0d].rd_rnid", d), m_exp[d].rd_rnid, i_rn[d].rd_rnid);
          compare_field($sformatf("o_rn[%0d].old_rnid", d), m_exp[d].old_rnid, i_rn[d].old_rnid);
          for (int s = 0; s < NUM_SRC; s++) begin
            compare_field($sformatf("o_rn[%0d].rs[%0d].rnid", d, s),
                          m_exp[d].rs[s].rnid, i_rn[d].rs[s].rnid);
            compare_field($sformatf("o_rn[%0d].rs[%0d].ready", d, s),
                          m_exp[d].rs[s].ready, i_rn[d].rs[s].ready);
          end
          if (m_exp[d].rd_rnid != 0) commit_pool.push_back(m_exp[d].old_rnid);
        end
      end
    end
  end

endmodule

//--- verification/rename_sva.sv
module rename_sva (
  input logic                i_clk,
  input logic                i_reset_n,
  input logic                i_rn_valid,
  input rename_pkg::rn_grp_t i_rn
);
  timeunit 1ns;
  timeprecision 1ps;
  import rename_pkg::*;

  int fail_count;   // failed assertions so far

  initial fail_count = 0;

  a_no_valid_in_reset: assert property (@(posedge i_clk) !i_reset_n |-> !i_rn_valid)
    else begin
      fail_count++;
      $error("output valid seen while in reset");
    end

  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_lane
    a_rd_has_id: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (i_rn_valid && i_rn[d].valid && i_rn[d].rd.valid && (i_rn[d].rd.idx != '0))
      |-> (i_rn[d].rd_rnid != '0))
      else begin
        fail_count++;
        $error("lane %0d writes a register but carries id 0", d);
      end
  end

  a_unique_ids: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_rn_valid && (i_rn[0].rd_rnid != '0)) |-> (i_rn[0].rd_rnid != i_rn[1].rd_rnid))
    else begin
      fail_count++;
      $error("both lanes carry the same new id");
    end

endmodule

bind rename_top rename_sva u_sva (
  .i_clk      (i_clk),
  .i_reset_n  (i_reset_n),
  .i_rn_valid (o_rn_valid),
  .i_rn       (o_rn)
);

//--- verification/rename_tb.sv
module rename_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rename_pkg::*;

  typedef struct packed {
    logic                       rnd;     // filler row, indices from the lfsr
    disp_grp_t                  grp;
    logic [DISP_SIZE-1:0]       cmask;   // lanes that commit the oldest free old id
    wb_t  [WB_PORTS-1:0]        wb;
    logic [3:0]                 idle;
  } row_t;

  logic                  i_clk;
  logic                  i_reset_n;
  logic                  i_disp_valid;
  disp_grp_t             i_disp;
  logic                  i_resource_ok;
  commit_t               i_commit;
  wb_t [WB_PORTS-1:0]    i_wb;
  logic                  o_disp_ready;
  logic                  o_rn_valid;
  rn_grp_t               o_rn;
  int                    error_count;
  int                    check_count;
  int                    cycles;
  int                    cycle_limit;
  logic [31:0]           lfsr_state;
  row_t                  rows [$];

  tb_clkgen u_clkgen (.o_clk(i_clk), .o_reset_n(i_reset_n));

  rename_top u_dut (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_disp_valid(i_disp_valid), .i_disp(i_disp),
    .i_resource_ok(i_resource_ok), .i_commit(i_commit), .i_wb(i_wb),
    .o_disp_ready(o_disp_ready), .o_rn_valid(o_rn_valid), .o_rn(o_rn)
  );

  rename_checker u_chk (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_disp_valid(i_disp_valid), .i_disp(i_disp),
    .i_resource_ok(i_resource_ok), .i_commit(i_commit), .i_wb(i_wb),
    .i_disp_ready(o_disp_ready), .i_rn_valid(o_rn_valid), .i_rn(o_rn),
    .o_error_count(error_count), .o_check_count(check_count)
  );

  // --------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic disp_inst_t mk_inst(input logic v, input logic rdv, input int rd,
                                         input logic s0v, input int s0,
                                         input logic s1v, input int s1);
    disp_inst_t x;
    x.valid     = v;
    x.rd        = '{rdv, regidx_t'(rd)};
    x.rs[0]     = '{s0v, regidx_t'(s0)};
    x.rs[1]     = '{s1v, regidx_t'(s1)};
    return x;
  endfunction

  function automatic wb_t mk_wb(input logic v, input int id);
    return '{v, rnid_t'(id)};
  endfunction

  task automatic add_row(input logic rnd, input disp_inst_t l0, input disp_inst_t l1,
                         input logic [1:0] cm, input wb_t w0, input wb_t w1, input int idle);
    row_t r;
    r.rnd   = rnd;
    r.grp   = {l1, l0};
    r.cmask = cm;
    r.wb    = {w1, w0};
    r.idle  = 4'(idle);
    rows.push_back(r);
  endtask

  // oldest committable ids, one per requested lane
  task automatic pick_commit(input logic [1:0] mask, output commit_t c);
    c = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (mask[d] && (u_chk.commit_pool.size() > 0)) begin
        c.valid[d]    = 1'b1;
        c.old_rnid[d] = u_chk.commit_pool.pop_front();
      end
    end
  endtask

  task automatic apply_row(input row_t r);
    disp_grp_t           g;
    wb_t [WB_PORTS-1:0]  w;
    commit_t             c;
    logic                ok;
    logic                fired;
    int                  stall;
    g  = r.grp;
    w  = r.wb;
    ok = 1'b1;
    if (r.rnd) begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        g[d] = mk_inst(1'b1, 1'b1, rand_bits(5), rand_bits(1) == 1, rand_bits(5),
                       rand_bits(1) == 1, rand_bits(5));
      end
      for (int p = 0; p < WB_PORTS; p++) begin
        w[p] = mk_wb(rand_bits(1) == 1, rand_bits(6));
      end
      ok = (rand_bits(2) != 0);   // allocator busy now and then
    end
    pick_commit(r.cmask, c);
    i_disp_valid  <= 1'b1;
    i_disp        <= g;
    i_commit      <= c;
    i_wb          <= w;
    i_resource_ok <= ok;
    fired = 1'b0;
    stall = 0;
    while (!fired) begin   // group waits at the input until it fires
      @(posedge i_clk);
      fired = i_disp_valid && o_disp_ready;
      i_commit      <= '0;
      i_wb          <= '0;
      i_resource_ok <= 1'b1;
      if (!fired) begin
        stall++;
        if (stall == 4) begin   // free lists dry, hand back old ids
          pick_commit(2'b11, c);
          i_commit <= c;
          stall = 0;
        end
      end
    end
    if (r.idle != 0) begin
      i_disp_valid <= 1'b0;
      i_disp       <= '0;
      repeat (r.idle) @(posedge i_clk);
    end
  endtask

  // --------------------------------------------------
  // table and run
  // --------------------------------------------------
  initial begin
    lfsr_state    = 32'he0459453;
    i_disp_valid  = 1'b0;
    i_disp        = '0;
    i_resource_ok = 1'b1;
    i_commit      = '0;
    i_wb          = '0;
    add_row(0, mk_inst(1,1,1, 1,2, 1,3), mk_inst(1,1,4, 1,5, 1,6), 0, 0, 0, 1);
    add_row(0, mk_inst(1,1,0, 1,1, 1,7), mk_inst(1,1,8, 1,4, 0,0), 0, 0, 0, 0);   // x0 rd
    add_row(0, mk_inst(1,1,9, 1,1, 0,0), mk_inst(1,1,9, 1,9, 1,8), 0, 0, 0, 0);   // same rd
    add_row(0, mk_inst(1,1,10, 1,1, 1,4), mk_inst(1,1,11, 1,8, 0,0), 0,
            mk_wb(1, 32), mk_wb(1, 48), 0);
    add_row(0, mk_inst(1,1,0, 1,1, 1,4), mk_inst(0,0,0, 0,0, 0,0), 0, 0, 0, 2);
    add_row(0, mk_inst(1,0,3, 1,9, 1,10), mk_inst(1,1,12, 1,11, 1,12), 2'b11, 0, 0, 0);
    add_row(0, mk_inst(1,1,13, 1,13, 0,0), mk_inst(1,1,13, 1,13, 1,0), 0, 0, 0, 1);
    for (int i = 0; i < 24; i++) begin
      add_row(1, '0, '0, 0, 0, 0, i % 3);
    end
    cycle_limit = rows.size() * 12 + 20;
    @(posedge i_reset_n);
    @(posedge i_clk);
    foreach (rows[i]) apply_row(rows[i]);
    repeat (3) @(posedge i_clk);
    $display("checks %0d errors %0d assertion failures %0d",
             check_count, error_count, u_dut.u_sva.fail_count);
    if ((error_count == 0) && (u_dut.u_sva.fail_count == 0)) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial cycles = 0;

  always @(posedge i_clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, dispatch never completed", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

//--- verilog.f
rtl/rename_pkg.sv
rtl/rn_freelist.sv
rtl/rn_map.sv
rtl/rn_group_bypass.sv
rtl/rn_inflight.sv
rtl/rename_top.sv
verification/tb_clkgen.sv
verification/rename_checker.sv
verification/rename_sva.sv
verification/rename_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rename stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module rename_tb -o rename_sim
./obj_dir/rename_sim | tee sim.log

# pass only if the pass line was printed
grep -qx '\*\* PASS \*\*' sim.log
echo "simulation passed"
